// ==== exec_cfg.svh ====
/*
 * Configuration macros for the execute stage:
 * data width, register address width, credit depth, multiply/divide steps
 */
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

`define EXEC_XLEN      32
`define EXEC_REG_AW    5
`define EXEC_CREDITS   4
`define EXEC_MD_STEPS  32

`endif

// ==== execPkg.sv ====
/*
 * Execute stage types: opcode and multiply/divide state enums,
 * issue, forwarding and result structs
 */
`include "exec_cfg.svh"

package execPkg;

    typedef enum logic [4:0] {
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_NOR,
        OP_SLT, OP_SLTU,
        OP_SLL, OP_SRL, OP_SRA,
        OP_LUI, OP_PASS,
        OP_MULT, OP_MULTU, OP_DIV, OP_DIVU,
        OP_MFHI, OP_MFLO
    } execOp_e;

    typedef enum logic [1:0] {
        MD_IDLE,
        MD_RUN,
        MD_FIX
    } mdState_e;

    typedef struct packed {
        execOp_e                 op;
        logic [31:0]             pc;
        logic [`EXEC_REG_AW-1:0] rsAddr;
        logic [`EXEC_REG_AW-1:0] rtAddr;
        logic [`EXEC_XLEN-1:0]   rsData;
        logic [`EXEC_XLEN-1:0]   rtData;
        logic [15:0]             imm16;
        logic [4:0]              shamt;
        logic                    useImm;
        logic                    zeroExt;
        logic [`EXEC_REG_AW-1:0] wbAddr;
    } issue_t;

    // Pending register write of a later stage, addr 0 means none
    typedef struct packed {
        logic [`EXEC_REG_AW-1:0] addr;
        logic [`EXEC_XLEN-1:0]   data;
    } fwd_t;

    typedef struct packed {
        execOp_e                 op;
        logic [31:0]             pc;
        logic [`EXEC_XLEN-1:0]   result;
        logic [`EXEC_XLEN-1:0]   storeData;
        logic [`EXEC_REG_AW-1:0] rtAddr;
        logic [`EXEC_REG_AW-1:0] wbAddr;
    } exResult_t;

endpackage

// ==== forwardSelect.sv ====
/*
 * Operand forwarding from memory and write-back stages,
 * immediate extension for operand B
 */
`include "exec_cfg.svh"

module forwardSelect import execPkg::*; (
    input  issue_t                issue,
    input  fwd_t                  memFwd,
    input  fwd_t                  wbFwd,
    output logic [`EXEC_XLEN-1:0] opA,
    output logic [`EXEC_XLEN-1:0] opB,
    output logic [`EXEC_XLEN-1:0] storeData
);
    logic [`EXEC_XLEN-1:0] rsVal;
    logic [`EXEC_XLEN-1:0] rtVal;
    logic [`EXEC_XLEN-1:0] immExt;

    // Memory stage is younger, so it wins over write-back
    assign rsVal = (memFwd.addr != '0 && memFwd.addr == issue.rsAddr) ? memFwd.data :
                   (wbFwd.addr != '0 && wbFwd.addr == issue.rsAddr) ? wbFwd.data :
                   issue.rsData;
    assign rtVal = (memFwd.addr != '0 && memFwd.addr == issue.rtAddr) ? memFwd.data :
                   (wbFwd.addr != '0 && wbFwd.addr == issue.rtAddr) ? wbFwd.data :
                   issue.rtData;

    assign immExt = issue.zeroExt ? {16'b0, issue.imm16} : {{16{issue.imm16[15]}}, issue.imm16};

    assign opA       = rsVal;
    assign opB       = issue.useImm ? immExt : rtVal;
    assign storeData = rtVal;
endmodule

// ==== alu.sv ====
/*
 * Single-cycle ALU: add/sub, logic, shifts, compares, LUI and pass
 */
`include "exec_cfg.svh"

module alu import execPkg::*; (
    input  execOp_e               op,
    input  logic [`EXEC_XLEN-1:0] opA,
    input  logic [`EXEC_XLEN-1:0] opB,
    input  logic [4:0]            shamt,
    output logic [`EXEC_XLEN-1:0] result
);
    logic sltS;
    logic sltU;

    assign sltS = $signed(opA) < $signed(opB);
    assign sltU = opA < opB;

    always_comb begin
        case (op)
            OP_ADD:  result = opA + opB;
            OP_SUB:  result = opA - opB;
            OP_AND:  result = opA & opB;
            OP_OR:   result = opA | opB;
            OP_XOR:  result = opA ^ opB;
            OP_NOR:  result = ~(opA | opB);
            OP_SLT:  result = {{(`EXEC_XLEN-1){1'b0}}, sltS};
            OP_SLTU: result = {{(`EXEC_XLEN-1){1'b0}}, sltU};
            // Shifts work on rt, as in MIPS
            OP_SLL:  result = opB << shamt;
            OP_SRL:  result = opB >> shamt;
            OP_SRA:  result = $unsigned($signed(opB) >>> shamt);
            OP_LUI:  result = {opB[15:0], 16'b0};
            OP_PASS: result = opB;
            // Mul/div issue carries operand A down the pipe
            OP_MULT,
            OP_MULTU,
            OP_DIV,
            OP_DIVU: result = opA;
            default: result = '0;
        endcase
    end
endmodule

// ==== mulDivCtrl.sv ====
/*
 * Multiply/divide FSM: start, iterate, sign fix, busy status
 */
module mulDivCtrl import execPkg::*; (
    input  logic    clk,
    input  logic    arstN,
    input  logic    mdStart,
    input  execOp_e mdOp,
    input  logic    lastStep,
    output logic    cntEn,
    output logic    cntClear,
    output logic    step,
    output logic    fix,
    output logic    mdBusy
);
    mdState_e state;
    mdState_e stateNext;
    logic     startOk;

    // Only genuine mul/div ops launch the unit
    assign startOk = mdStart && (mdOp inside {OP_MULT, OP_MULTU, OP_DIV, OP_DIVU});

    always_comb begin
        stateNext = state;
        case (state)
            MD_IDLE: if (startOk) stateNext = MD_RUN;
            MD_RUN:  if (lastStep) stateNext = MD_FIX;
            MD_FIX:  stateNext = MD_IDLE;
            default: stateNext = MD_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= MD_IDLE;
        end else begin
            state <= stateNext;
        end
    end

    assign cntClear = (state == MD_IDLE) && startOk;
    assign cntEn    = (state == MD_RUN);
    assign step     = (state == MD_RUN);
    assign fix      = (state == MD_FIX);
    assign mdBusy   = (state != MD_IDLE);
endmodule

// ==== mulDivCounter.sv ====
/*
 * Step counter for one multiply/divide, flags the final step
 */
`include "exec_cfg.svh"

module mulDivCounter (
    input  logic clk,
    input  logic arstN,
    input  logic cntClear,
    input  logic cntEn,
    output logic lastStep
);
    localparam int CNT_W = $clog2(`EXEC_MD_STEPS);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            count <= '0;
        end else if (cntClear) begin
            count <= '0;
        end else if (cntEn) begin
            count <= count + 1'b1;
        end
    end

    assign lastStep = (count == CNT_W'(`EXEC_MD_STEPS - 1));
endmodule

// ==== mulDivDatapath.sv ====
/*
 * Shift-add multiplier, restoring divider and HI/LO registers
 */
`include "exec_cfg.svh"

module mulDivDatapath import execPkg::*; (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  mdStart,
    input  execOp_e               mdOp,
    input  logic [`EXEC_XLEN-1:0] opA,
    input  logic [`EXEC_XLEN-1:0] opB,
    input  logic                  step,
    input  logic                  fix,
    output logic [`EXEC_XLEN-1:0] hi,
    output logic [`EXEC_XLEN-1:0] lo
);
    localparam int XL = `EXEC_XLEN;

    logic              isSigned;
    logic              negAIn;
    logic              negBIn;
    logic [2*XL-1:0]   acc;
    logic [XL-1:0]     magB;
    logic              isDiv;
    logic              negA;
    logic              negB;
    logic [XL:0]       mulSum;
    logic [XL+1:0]     divDiff;
    logic [2*XL-1:0]   prodFix;
    logic [XL-1:0]     quotFix;
    logic [XL-1:0]     remFix;

    assign isSigned = (mdOp == OP_MULT) || (mdOp == OP_DIV);
    assign negAIn   = isSigned && opA[XL-1];
    assign negBIn   = isSigned && opB[XL-1];

    // Add multiplicand into the upper half when the low bit is set
    assign mulSum  = {1'b0, acc[2*XL-1:XL]} + (acc[0] ? {1'b0, magB} : '0);
    // Trial subtract of the shifted partial remainder
    assign divDiff = {1'b0, acc[2*XL-1:XL-1]} - {2'b0, magB};

    always_ff @(posedge clk) begin
        if (mdStart) begin
            isDiv <= (mdOp == OP_DIV) || (mdOp == OP_DIVU);
            negA  <= negAIn;
            negB  <= negBIn;
            acc   <= {{XL{1'b0}}, negAIn ? -opA : opA};
            magB  <= negBIn ? -opB : opB;
        end else if (step) begin
            if (!isDiv) begin
                acc <= {mulSum, acc[XL-1:1]};
            end else if (!divDiff[XL+1]) begin
                acc <= {divDiff[XL-1:0], acc[XL-2:0], 1'b1};
            end else begin
                acc <= {acc[2*XL-2:0], 1'b0};
            end
        end
    end

    assign prodFix  = (negA ^ negB) ? -acc : acc;
    assign quotFix  = (negA ^ negB) ? -acc[XL-1:0] : acc[XL-1:0];
    assign remFix   = negA ? -acc[2*XL-1:XL] : acc[2*XL-1:XL];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            hi <= '0;
            lo <= '0;
        end else if (fix) begin
            if (!isDiv) begin
                hi <= prodFix[2*XL-1:XL];
                lo <= prodFix[XL-1:0];
            end else begin
                // A zero divisor leaves the dividend as remainder
                hi <= remFix;
                // and gives an all-ones quotient
                lo <= (magB == '0) ? '1 : quotFix;
            end
        end
    end
endmodule

// ==== execOutReg.sv ====
/*
 * Execute-to-memory pipeline register, issue acceptance,
 * credit counter and mul/div start
 */
`include "exec_cfg.svh"

module execOutReg import execPkg::*; (
    input  logic                  clk,
    input  logic                  arstN,
    input  issue_t                issue,
    input  logic                  issueValid,
    output logic                  issueReady,
    input  logic                  mdBusy,
    input  logic [`EXEC_XLEN-1:0] aluResult,
    input  logic [`EXEC_XLEN-1:0] hi,
    input  logic [`EXEC_XLEN-1:0] lo,
    input  logic [`EXEC_XLEN-1:0] storeData,
    input  logic                  creditReturn,
    output exResult_t             out,
    output logic                  outValid,
    output logic                  mdStart
);
    localparam int CW = $clog2(`EXEC_CREDITS + 1);

    logic [CW-1:0]         credits;
    logic                  isMd;
    logic                  isMfx;
    logic                  accept;
    logic [`EXEC_XLEN-1:0] resultSel;

    assign isMd  = issue.op inside {OP_MULT, OP_MULTU, OP_DIV, OP_DIVU};
    assign isMfx = (issue.op == OP_MFHI) || (issue.op == OP_MFLO);

    assign issueReady = (credits != '0) && !(mdBusy && (isMd || isMfx));
    assign accept     = issueValid && issueReady;
    assign mdStart    = accept && isMd;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            credits <= CW'(`EXEC_CREDITS);
        end else if (accept && !creditReturn) begin
            credits <= credits - 1'b1;
        end else if (!accept && creditReturn && credits != CW'(`EXEC_CREDITS)) begin
            credits <= credits + 1'b1;
        end
    end

    assign resultSel = (issue.op == OP_MFHI) ? hi :
                       (issue.op == OP_MFLO) ? lo : aluResult;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
        end else begin
            outValid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out.op        <= issue.op;
            out.pc        <= issue.pc;
            out.result    <= resultSel;
            out.storeData <= storeData;
            out.rtAddr    <= issue.rtAddr;
            out.wbAddr    <= issue.wbAddr;
        end
    end
endmodule

// ==== execStage.sv ====
/*
 * Execute stage top: forwarding, ALU, multiply/divide unit, output register
 */
`include "exec_cfg.svh"

module execStage import execPkg::*; (
    input  logic      clk,
    input  logic      arstN,
    input  issue_t    issue,
    input  logic      issueValid,
    output logic      issueReady,
    input  fwd_t      memFwd,
    input  fwd_t      wbFwd,
    output exResult_t out,
    output logic      outValid,
    input  logic      creditReturn,
    output logic      mdBusy
);
    logic [`EXEC_XLEN-1:0] opA;
    logic [`EXEC_XLEN-1:0] opB;
    logic [`EXEC_XLEN-1:0] storeData;
    logic [`EXEC_XLEN-1:0] aluResult;
    logic [`EXEC_XLEN-1:0] hi;
    logic [`EXEC_XLEN-1:0] lo;
    logic                  mdStart;
    logic                  cntEn;
    logic                  cntClear;
    logic                  step;
    logic                  fix;
    logic                  lastStep;

    forwardSelect u_fwd (
        .issue(issue), .memFwd(memFwd), .wbFwd(wbFwd),
        .opA(opA), .opB(opB), .storeData(storeData)
    );

    alu u_alu (
        .op(issue.op), .opA(opA), .opB(opB), .shamt(issue.shamt), .result(aluResult)
    );

    mulDivCtrl u_mdCtrl (
        .clk(clk), .arstN(arstN), .mdStart(mdStart), .mdOp(issue.op),
        .lastStep(lastStep), .cntEn(cntEn), .cntClear(cntClear),
        .step(step), .fix(fix), .mdBusy(mdBusy)
    );

    mulDivCounter u_mdCnt (
        .clk(clk), .arstN(arstN), .cntClear(cntClear), .cntEn(cntEn), .lastStep(lastStep)
    );

    mulDivDatapath u_mdData (
        .clk(clk), .arstN(arstN), .mdStart(mdStart), .mdOp(issue.op),
        .opA(opA), .opB(opB), .step(step), .fix(fix), .hi(hi), .lo(lo)
    );

    execOutReg u_outReg (
        .clk(clk), .arstN(arstN), .issue(issue), .issueValid(issueValid),
        .issueReady(issueReady), .mdBusy(mdBusy), .aluResult(aluResult),
        .hi(hi), .lo(lo), .storeData(storeData), .creditReturn(creditReturn),
        .out(out), .outValid(outValid), .mdStart(mdStart)
    );
endmodule

// ==== tb_clock.sv ====
/*
 * Testbench clock and active-low reset generator
 */
module tb_clock #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic arstN
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Release on a rising edge after the reset cycles
    initial begin
        arstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arstN <= 1'b1;
    end
endmodule

// ==== execStage_asserts.sv ====
/*
 * Bound checker for the execute stage: reference model for forwarding,
 * ALU results, HI/LO and credits, with concurrent assertions
 */
`include "exec_cfg.svh"

module execStage_asserts import execPkg::*; (
    input logic      clk,
    input logic      arstN,
    input issue_t    issue,
    input logic      issueValid,
    input logic      issueReady,
    input fwd_t      memFwd,
    input fwd_t      wbFwd,
    input exResult_t out,
    input logic      outValid,
    input logic      creditReturn,
    input logic      mdBusy
);
    localparam int XL          = `EXEC_XLEN;
    localparam int MAX_CRED    = `EXEC_CREDITS;
    localparam int BUSY_CYCLES = `EXEC_MD_STEPS + 1;

    int valueErrors    = 0;
    int protocolErrors = 0;

    logic          accept;
    logic          isMd;
    logic          isMfx;
    logic [XL-1:0] refA;
    logic [XL-1:0] refRt;
    logic [XL-1:0] refB;
    logic [XL-1:0] immVal;
    logic [XL-1:0] refHi;
    logic [XL-1:0] refLo;
    logic          expValid;
    exResult_t     expOut;
    int            refCredits;
    int            credNext;
    int            inFlight;

    // Register zero never forwards, memory stage before write-back
    function automatic logic [XL-1:0] fwdPick(input logic [4:0] addr,
                                              input logic [XL-1:0] regData,
                                              input fwd_t mem, input fwd_t wb);
        if (addr == 5'd0) begin
            return regData;
        end
        if (mem.addr == addr) begin
            return mem.data;
        end
        if (wb.addr == addr) begin
            return wb.data;
        end
        return regData;
    endfunction

    function automatic logic [XL-1:0] refResult(input execOp_e op, input logic [XL-1:0] a,
                                                input logic [XL-1:0] b, input logic [4:0] sh,
                                                input logic [XL-1:0] hiV,
                                                input logic [XL-1:0] loV);
        logic [XL-1:0] r;
        case (op)
            OP_ADD:  r = a + b;
            OP_SUB:  r = a + ~b + 1'b1;
            OP_AND:  r = a & b;
            OP_OR:   r = a | b;
            OP_XOR:  r = a ^ b;
            OP_NOR:  r = ~a & ~b;
            // Differing signs decide by the sign of a alone
            OP_SLT:  r = (a[XL-1] != b[XL-1]) ? XL'(a[XL-1]) : XL'(a < b);
            OP_SLTU: r = XL'(a < b);
            OP_SLL:  r = b << sh;
            OP_SRL:  r = b >> sh;
            OP_SRA:  r = (b >> sh) | (b[XL-1] ? ~({XL{1'b1}} >> sh) : '0);
            OP_LUI:  r = b << 16;
            OP_PASS: r = b;
            OP_MULT, OP_MULTU, OP_DIV, OP_DIVU: r = a;
            OP_MFHI: r = hiV;
            OP_MFLO: r = loV;
            default: r = '0;
        endcase
        return r;
    endfunction

    // Returns {HI, LO}
    function automatic logic [2*XL-1:0] refHiLo(input execOp_e op, input logic [XL-1:0] a,
                                                input logic [XL-1:0] b);
        logic                   sgn;
        logic signed [2*XL-1:0] sa;
        logic signed [2*XL-1:0] sb;
        logic signed [2*XL-1:0] q;
        logic signed [2*XL-1:0] rm;
        sgn = (op == OP_MULT) || (op == OP_DIV);
        sa  = sgn ? {{XL{a[XL-1]}}, a} : {{XL{1'b0}}, a};
        sb  = sgn ? {{XL{b[XL-1]}}, b} : {{XL{1'b0}}, b};
        if (op == OP_MULT || op == OP_MULTU) begin
            return sa * sb;
        end
        if (b == '0) begin
            return {a, {XL{1'b1}}};
        end
        q  = sa / sb;
        rm = sa % sb;
        return {rm[XL-1:0], q[XL-1:0]};
    endfunction

    assign isMd   = issue.op inside {OP_MULT, OP_MULTU, OP_DIV, OP_DIVU};
    assign isMfx  = issue.op inside {OP_MFHI, OP_MFLO};
    assign accept = issueValid && issueReady;

    always_comb begin
        refA   = fwdPick(issue.rsAddr, issue.rsData, memFwd, wbFwd);
        refRt  = fwdPick(issue.rtAddr, issue.rtData, memFwd, wbFwd);
        immVal = issue.zeroExt ? XL'(issue.imm16) : XL'($signed(issue.imm16));
        refB   = issue.useImm ? immVal : refRt;
        credNext = refCredits + int'(creditReturn) - int'(accept);
        if (credNext > MAX_CRED) begin
            credNext = MAX_CRED;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            expValid   <= 1'b0;
            expOut     <= '0;
            refHi      <= '0;
            refLo      <= '0;
            refCredits <= MAX_CRED;
            inFlight   <= 0;
        end else begin
            expValid <= accept;
            if (accept) begin
                expOut.op        <= issue.op;
                expOut.pc        <= issue.pc;
                expOut.result    <= refResult(issue.op, refA, refB, issue.shamt, refHi, refLo);
                expOut.storeData <= refRt;
                expOut.rtAddr    <= issue.rtAddr;
                expOut.wbAddr    <= issue.wbAddr;
                if (isMd) begin
                    {refHi, refLo} <= refHiLo(issue.op, refA, refB);
                end
            end
            refCredits <= credNext;
            inFlight   <= inFlight + int'(outValid) - int'(creditReturn);
        end
    end

    aResetState: assert property (@(posedge clk) $rose(arstN) |-> !outValid && !mdBusy && issueReady)
        else begin
            protocolErrors++;
            $error("Reset state wrong: outValid or mdBusy high, or no credit available");
        end

    aOutValid: assert property (@(posedge clk) disable iff (!arstN) outValid == expValid)
        else begin
            valueErrors++;
            $error("MISMATCH outValid: got %h expected %h", $sampled(outValid), $sampled(expValid));
        end

    aResult: assert property (@(posedge clk) disable iff (!arstN)
            outValid |-> out.result == expOut.result)
        else begin
            valueErrors++;
            $error("MISMATCH out.result: got %h expected %h",
                   $sampled(out.result), $sampled(expOut.result));
        end

    aStoreData: assert property (@(posedge clk) disable iff (!arstN)
            outValid |-> out.storeData == expOut.storeData)
        else begin
            valueErrors++;
            $error("MISMATCH out.storeData: got %h expected %h",
                   $sampled(out.storeData), $sampled(expOut.storeData));
        end

    aTags: assert property (@(posedge clk) disable iff (!arstN)
            outValid |-> {out.op, out.pc, out.rtAddr, out.wbAddr} ==
                         {expOut.op, expOut.pc, expOut.rtAddr, expOut.wbAddr})
        else begin
            valueErrors++;
            $error("MISMATCH out.op/pc/rtAddr/wbAddr: got %h expected %h",
                   $sampled({out.op, out.pc, out.rtAddr, out.wbAddr}),
                   $sampled({expOut.op, expOut.pc, expOut.rtAddr, expOut.wbAddr}));
        end

    aCreditZero: assert property (@(posedge clk) disable iff (!arstN)
            refCredits == 0 |-> !issueReady)
        else begin
            protocolErrors++;
            $error("issueReady high with no credits left");
        end

    aInFlight: assert property (@(posedge clk) disable iff (!arstN) inFlight <= MAX_CRED)
        else begin
            protocolErrors++;
            $error("More results outstanding than credits granted");
        end

    aReadyRule: assert property (@(posedge clk) disable iff (!arstN)
            issueReady == (refCredits != 0 && !(mdBusy && (isMd || isMfx))))
        else begin
            valueErrors++;
            $error("MISMATCH issueReady: got %h expected %h", $sampled(issueReady),
                   $sampled(refCredits != 0 && !(mdBusy && (isMd || isMfx))));
        end

    aBusyHold: assert property (@(posedge clk) disable iff (!arstN)
            mdBusy && issueValid && (isMd || isMfx) |-> !issueReady)
        else begin
            protocolErrors++;
            $error("HI/LO access or multiply/divide accepted while the unit is busy");
        end

    aBusyWindow: assert property (@(posedge clk) disable iff (!arstN)
            accept && isMd |=> mdBusy [*BUSY_CYCLES] ##1 !mdBusy)
        else begin
            protocolErrors++;
            $error("mdBusy window after a multiply/divide start has the wrong length");
        end
endmodule

bind execStage execStage_asserts u_asserts (.*);

// ==== tb_execStage.sv ====
/*
 * Testbench for the execute stage: LFSR stimulus, credit returns,
 * timeout and final report
 */
`include "exec_cfg.svh"

module tb_execStage import execPkg::*; ();
    localparam int TOTAL_INSTR = 600;
    localparam int CYCLE_LIMIT = TOTAL_INSTR * (`EXEC_MD_STEPS + 4);

    logic        clk;
    logic        arstN;
    issue_t      issue;
    logic        issueValid;
    logic        issueReady;
    fwd_t        memFwd;
    fwd_t        wbFwd;
    exResult_t   out;
    logic        outValid;
    logic        creditReturn;
    logic        mdBusy;
    logic [15:0] lfsrState;
    int          cycles;
    int          accepted;
    int          outstanding;
    int          holdLeft;
    int          timeouts;
    int          totalErrors;

    tb_clock #(.PERIOD(8), .RESET_CYCLES(5)) u_clk (.clk(clk), .arstN(arstN));

    execStage u_dut (
        .clk(clk), .arstN(arstN), .issue(issue), .issueValid(issueValid),
        .issueReady(issueReady), .memFwd(memFwd), .wbFwd(wbFwd), .out(out),
        .outValid(outValid), .creditReturn(creditReturn), .mdBusy(mdBusy)
    );

    // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb        = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
            lfsrState = {lfsrState[14:0], fb};
            value     = {value[30:0], fb};
        end
        return value;
    endfunction

    // Corner values for signed multiply/divide mixed with random data
    function automatic logic [31:0] pickData();
        logic [1:0] kind;
        kind = 2'(randBits(2));
        case (kind)
            2'd0:    return 32'h8000_0000;
            2'd1:    return 32'hFFFF_FFFF;
            default: return randBits(32);
        endcase
    endfunction

    task automatic buildInstr(input int seq, output issue_t ins, output fwd_t mem,
                              output fwd_t wb);
        logic isMd;
        ins.op      = execOp_e'(5'(randBits(5) % 19));
        isMd        = ins.op inside {OP_MULT, OP_MULTU, OP_DIV, OP_DIVU};
        ins.pc      = 32'h0040_0000 + 32'(seq) * 4;
        ins.rsAddr  = 5'(randBits(3));
        ins.rtAddr  = 5'(randBits(3));
        ins.rsData  = pickData();
        ins.rtData  = pickData();
        ins.imm16   = 16'(randBits(16));
        ins.shamt   = 5'(randBits(5));
        ins.useImm  = 1'(randBits(1));
        ins.zeroExt = 1'(randBits(1));
        ins.wbAddr  = 5'(randBits(5));
        case (ins.op)
            OP_SLL, OP_SRL, OP_SRA, OP_MFHI, OP_MFLO: ins.useImm = 1'b0;
            OP_LUI:  ins.useImm = 1'b1;
            default: ins.useImm = ins.useImm;
        endcase
        if (isMd) begin
            ins.useImm = 1'b0;
            ins.wbAddr = '0;
            // Register zero as divisor now and then
            if (randBits(2) == 0) begin
                ins.rtAddr = '0;
                ins.rtData = '0;
            end
        end
        mem.addr = 5'(randBits(3));
        mem.data = pickData();
        wb.addr  = 5'(randBits(3));
        wb.data  = pickData();
        // Same register pending in both later stages
        if (randBits(2) == 0) begin
            wb.addr = mem.addr;
        end
    endtask

    initial begin
        issue_t ins;
        fwd_t   memNext;
        fwd_t   wbNext;
        logic   done;
        lfsrState    = 16'd33072;
        issue        = '0;
        issueValid   = 1'b0;
        memFwd       = '0;
        wbFwd        = '0;
        creditReturn = 1'b0;
        cycles       = 0;
        accepted     = 0;
        outstanding  = 0;
        holdLeft     = 0;
        timeouts     = 0;
        done         = 1'b0;
        @(posedge arstN);
        while (!done) begin
            @(posedge clk);
            cycles++;
            if (issueValid && issueReady) begin
                accepted++;
            end
            outstanding += int'(outValid) - int'(creditReturn);
            // Decode holds the instruction until it is taken
            if (!issueValid || issueReady) begin
                if (accepted < TOTAL_INSTR && randBits(3) != 0) begin
                    buildInstr(accepted, ins, memNext, wbNext);
                    issue      <= ins;
                    memFwd     <= memNext;
                    wbFwd      <= wbNext;
                    issueValid <= 1'b1;
                end else begin
                    issueValid <= 1'b0;
                end
            end
            // Memory stage stalls its credit returns in stretches
            if (holdLeft > 0) begin
                holdLeft--;
                creditReturn <= 1'b0;
            end else if (randBits(4) == 0) begin
                holdLeft = randBits(4) + 1;
                creditReturn <= 1'b0;
            end else begin
                creditReturn <= (outstanding > 0) && randBits(1);
            end
            if (accepted >= TOTAL_INSTR && !issueValid && outstanding == 0 && !outValid
                && !mdBusy) begin
                done = 1'b1;
            end else if (cycles >= CYCLE_LIMIT) begin
                timeouts++;
                $display("Timeout: run stopped at cycle %0d with %0d of %0d instructions accepted",
                         cycles, accepted, TOTAL_INSTR);
                done = 1'b1;
            end
        end
        repeat (2) @(posedge clk);
        totalErrors = u_dut.u_asserts.valueErrors + u_dut.u_asserts.protocolErrors + timeouts;
        $display("Checks done: %0d value errors, %0d protocol errors, %0d timeouts",
                 u_dut.u_asserts.valueErrors, u_dut.u_asserts.protocolErrors, timeouts);
        if (totalErrors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end
endmodule

// ==== tb.f ====
+incdir+.
execPkg.sv
forwardSelect.sv
alu.sv
mulDivCtrl.sv
mulDivCounter.sv
mulDivDatapath.sv
execOutReg.sv
execStage.sv
tb_clock.sv
execStage_asserts.sv
tb_execStage.sv

// ==== Bender.yml ====
package:
  name: exec_stage

export_include_dirs:
  - .

sources:
  - files:
      - execPkg.sv
      - forwardSelect.sv
      - alu.sv
      - mulDivCtrl.sv
      - mulDivCounter.sv
      - mulDivDatapath.sv
      - execOutReg.sv
      - execStage.sv
  - target: test
    files:
      - tb_clock.sv
      - execStage_asserts.sv
      - tb_execStage.sv
